/* common/bfp_pkg.sv */
// Block floating point package with the sample, mantissa and exponent types.

package bfp_pkg;

    // Unsigned input samples are fixed at this width.
    localparam int sample_width = 16;

    // Mantissas carry four spare bits above a sample.
    localparam int mant_width = sample_width + 4;

    // Leading-one positions run from 0 to sample_width-1.
    localparam int bexp_width = $clog2(sample_width);

    // One unsigned input sample.
    typedef logic [sample_width-1:0] sample_t;

    // One normalized output mantissa.
    typedef logic [mant_width-1:0] mant_t;

    // A leading-one position or the block exponent.
    typedef logic [bexp_width-1:0] bexp_t;

endpackage

/* source/bfp_sample_buffer.sv */
// Sample buffer that gathers N strobed samples and hands each full block on.

`timescale 1ns/1ps

module bfp_sample_buffer #(
    parameter int N = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sample_valid,
    input  bfp_pkg::sample_t sample_data,
    output logic            block_ready,
    output bfp_pkg::sample_t block_data [N]
);

    localparam int cnt_w = (N > 1) ? $clog2(N) : 1;

    logic [cnt_w-1:0] fill_count;         // slot that takes the next sample.
    bfp_pkg::sample_t slots [N-1];        // the last sample goes straight to block_data.
    logic             last_sample;

    assign last_sample = sample_valid && (fill_count == cnt_w'(N - 1));

    // Fill counter and block handover pulse.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_count  <= '0;
            block_ready <= 1'b0;
        end else begin
            block_ready <= last_sample;   // one cycle after the Nth sample.
            if (last_sample) begin
                fill_count <= '0;
            end else if (sample_valid) begin
                fill_count <= fill_count + 1'b1;
            end
        end
    end

    // Slot storage while the block fills.
    always_ff @(posedge clk) begin
        if (sample_valid && !last_sample) begin
            slots[fill_count] <= sample_data;
        end
    end

    // Copy out on the Nth sample so the next block can start right away.
    always_ff @(posedge clk) begin
        if (last_sample) begin
            for (int i = 0; i < N - 1; i++) begin
                block_data[i] <= slots[i];
            end
            block_data[N-1] <= sample_data;
        end
    end

endmodule

/* bfp_exponent/bfp_exponent_detect.sv */
// Exponent stage that finds each sample's leading one and the block maximum.

`timescale 1ns/1ps

module bfp_exponent_detect #(
    parameter int N = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             block_ready,
    input  bfp_pkg::sample_t block_data [N],
    output logic             exp_ready,
    output bfp_pkg::sample_t held_samples [N],
    output bfp_pkg::bexp_t   lead_pos [N],
    output bfp_pkg::bexp_t   max_exp
);

    // Priority encoder. A zero sample reports position 0.
    function automatic bfp_pkg::bexp_t lead_one(input bfp_pkg::sample_t value);
        bfp_pkg::bexp_t pos;
        pos = '0;
        for (int b = 0; b < bfp_pkg::sample_width; b++) begin
            if (value[b]) begin
                pos = bfp_pkg::bexp_t'(b); // higher bits overwrite lower ones.
            end
        end
        return pos;
    endfunction

    bfp_pkg::bexp_t pos_comb [N];
    bfp_pkg::bexp_t tree [N];
    bfp_pkg::bexp_t max_comb;

    // One encoder per sample.
    always_comb begin
        for (int i = 0; i < N; i++) begin
            pos_comb[i] = lead_one(block_data[i]);
        end
    end

    // Pairwise maximum tree. Each level halves the number of live nodes,
    // and odd leftovers pass through unchanged to the next level.
    always_comb begin
        for (int i = 0; i < N; i++) begin
            tree[i] = pos_comb[i];
        end
        for (int s = 1; s < N; s = s * 2) begin
            for (int i = 0; i + s < N; i = i + 2 * s) begin
                if (tree[i+s] > tree[i]) begin
                    tree[i] = tree[i+s];
                end
            end
        end
        max_comb = tree[0];                // root of the tree.
    end

    // Pulse that follows block_ready by one cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_ready <= 1'b0;
        end else begin
            exp_ready <= block_ready;
        end
    end

    // Block payload, positions and exponent are held until the next block.
    always_ff @(posedge clk) begin
        if (block_ready) begin
            for (int i = 0; i < N; i++) begin
                held_samples[i] <= block_data[i];
                lead_pos[i]     <= pos_comb[i];
            end
            max_exp <= max_comb;
        end
    end

endmodule

/* bfp_normalize/bfp_mantissa_shift.sv */
// Normalization stage that shifts each sample to the block exponent and streams it out.

`timescale 1ns/1ps

module bfp_mantissa_shift #(
    parameter int N = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             exp_ready,
    input  bfp_pkg::sample_t held_samples [N],
    input  bfp_pkg::bexp_t   lead_pos [N],
    input  bfp_pkg::bexp_t   max_exp,
    output logic             out_valid,
    output logic             out_first,
    output bfp_pkg::mant_t   out_mant,
    output bfp_pkg::bexp_t   block_exp
);

    localparam int cnt_w = (N > 1) ? $clog2(N) : 1;

    bfp_pkg::sample_t blk_samples [N];     // copy of the block being streamed.
    bfp_pkg::bexp_t   blk_pos [N];
    logic [cnt_w-1:0] out_idx;
    logic             active;
    bfp_pkg::bexp_t   shift_amt;

    // Output index and block exponent.
    // A new block may land on the same edge as the last beat of the old one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            out_idx   <= '0;
            block_exp <= '0;
        end else if (exp_ready) begin
            active    <= 1'b1;
            out_idx   <= '0;
            block_exp <= max_exp;
        end else if (active) begin
            if (out_idx == cnt_w'(N - 1)) begin
                active  <= 1'b0;
                out_idx <= '0;
            end else begin
                out_idx <= out_idx + 1'b1;
            end
        end
    end

    // Latch the block, since the exponent stage may load the next one mid-stream.
    always_ff @(posedge clk) begin
        if (exp_ready) begin
            for (int i = 0; i < N; i++) begin
                blk_samples[i] <= held_samples[i];
                blk_pos[i]     <= lead_pos[i];
            end
        end
    end

    assign shift_amt = block_exp - blk_pos[out_idx];   // never negative.

    assign out_valid = active;
    assign out_first = active && (out_idx == '0);
    assign out_mant  = bfp_pkg::mant_t'(blk_samples[out_idx]) << shift_amt;

endmodule

/* source/bfp_block_encoder.sv */
// Block floating point encoder top, chaining buffer, exponent and normalization stages.

`timescale 1ns/1ps

module bfp_block_encoder #(
    parameter int N = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sample_valid,
    input  bfp_pkg::sample_t sample_data,
    output logic             out_valid,
    output logic             out_first,
    output bfp_pkg::mant_t   out_mant,
    output bfp_pkg::bexp_t   block_exp
);

    logic             block_ready;
    bfp_pkg::sample_t block_data [N];
    logic             exp_ready;
    bfp_pkg::sample_t held_samples [N];
    bfp_pkg::bexp_t   lead_pos [N];
    bfp_pkg::bexp_t   max_exp;

    bfp_sample_buffer #(
        .N            (N)
    ) u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .block_ready  (block_ready),
        .block_data   (block_data)
    );

    bfp_exponent_detect #(
        .N            (N)
    ) u_exp (
        .clk          (clk),
        .rst_n        (rst_n),
        .block_ready  (block_ready),
        .block_data   (block_data),
        .exp_ready    (exp_ready),
        .held_samples (held_samples),
        .lead_pos     (lead_pos),
        .max_exp      (max_exp)
    );

    bfp_mantissa_shift #(
        .N            (N)
    ) u_shift (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_ready    (exp_ready),
        .held_samples (held_samples),
        .lead_pos     (lead_pos),
        .max_exp      (max_exp),
        .out_valid    (out_valid),
        .out_first    (out_first),
        .out_mant     (out_mant),
        .block_exp    (block_exp)
    );

endmodule

/* sim/bfp_sva.sv */
// Assertion checker bound to the block floating point encoder top.

`timescale 1ns/1ps

module bfp_sva (
    input logic           clk,
    input logic           rst_n,
    input logic           out_valid,
    input logic           out_first,
    input bfp_pkg::mant_t out_mant,
    input bfp_pkg::bexp_t block_exp
);

    int assert_errors = 0;                // count of failed assertions.

    first_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n) out_first |-> out_valid
    ) else begin
        $error("out_first high without out_valid");
        assert_errors++;
    end

    // every beat after the first belongs to the same block as the one before.
    exp_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (out_valid && !out_first) |-> $stable(block_exp)
    ) else begin
        $error("block_exp changed inside a block");
        assert_errors++;
    end

    // the leading one never lands above bit 15.
    mant_top_clear: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_mant[bfp_pkg::mant_width-1:bfp_pkg::sample_width] == '0)
    ) else begin
        $error("out_mant has bits set above the sample width");
        assert_errors++;
    end

    idle_in_reset: assert property (
        @(posedge clk) !rst_n |-> !out_valid
    ) else begin
        $error("out_valid high during reset");
        assert_errors++;
    end

endmodule

bind bfp_block_encoder bfp_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_first (out_first),
    .out_mant  (out_mant),
    .block_exp (block_exp)
);

/* sim/bfp_tb.sv */
// Testbench for the block floating point encoder, driven from a data file of blocks.

`timescale 1ns/1ps

module bfp_tb;

    localparam int n_samples       = 4;
    localparam int words_per_block = 10;  // gap mode, four samples, exponent, four mantissas.
    localparam int max_blocks      = 64;
    localparam int latency         = 3;   // last accepted sample to first output beat.

    logic             clk;
    logic             rst_n;
    logic             sample_valid;
    bfp_pkg::sample_t sample_data;
    logic             out_valid;
    logic             out_first;
    bfp_pkg::mant_t   out_mant;
    bfp_pkg::bexp_t   block_exp;

    logic [31:0] test_mem [max_blocks*words_per_block];

    bfp_pkg::bexp_t exp_q [$];            // one entry per block still to come out.
    bfp_pkg::mant_t mant_q [$];           // one entry per beat still to come out.
    int             strobe_cyc_q [$];     // cycle of each block's last strobe.

    integer seed;
    int     n_blocks;
    int     cycle_limit;
    int     cyc;
    int     strobe_count;
    int     beat_idx;
    int     blocks_done;
    int     pass_count;
    int     fail_count;
    int     stray_errors;
    logic   block_err;

    bfp_block_encoder #(
        .N            (n_samples)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .out_valid    (out_valid),
        .out_first    (out_first),
        .out_mant     (out_mant),
        .block_exp    (block_exp)
    );

    always #20 clk = ~clk;                // 40 ns period.

    task automatic check_exp(input string name, input bfp_pkg::bexp_t expected,
                             input bfp_pkg::bexp_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s exponent: expected %0d, actual %0d",
                     name, expected, actual);
            block_err = 1'b1;
        end
    endtask

    task automatic check_mant(input string name, input bfp_pkg::mant_t expected,
                              input bfp_pkg::mant_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s mantissa %0d: expected 0x%05h, actual 0x%05h",
                     name, beat_idx, expected, actual);
            block_err = 1'b1;
        end
    endtask

    task automatic close_block(input string name);
        if (block_err) begin
            fail_count++;
            $display("%s failed", name);
        end else begin
            pass_count++;
            $display("%s passed", name);
        end
        void'(exp_q.pop_front());
        blocks_done++;
        beat_idx  = 0;
        block_err = 1'b0;
    endtask

    task automatic record_beat(input string name);
        int lat;
        if (out_first !== (beat_idx == 0)) begin
            $display("%s: out_first was %b on beat %0d", name, out_first, beat_idx);
            block_err = 1'b1;
        end
        if (beat_idx == 0) begin
            if (strobe_cyc_q.size() == 0) begin
                $display("%s: output started before the last sample was sent", name);
                block_err = 1'b1;
            end else begin
                lat = cyc - strobe_cyc_q.pop_front();
                if (lat != latency) begin
                    $display("CHECK FAILED %s latency: expected %0d, actual %0d",
                             name, latency, lat);
                    block_err = 1'b1;
                end
            end
        end
        check_exp(name, exp_q[0], block_exp);
        check_mant(name, mant_q.pop_front(), out_mant);
        beat_idx++;
        if (beat_idx == n_samples) begin
            close_block(name);
        end
    endtask

    // Outputs are sampled on the falling edge, halfway between driving edges.
    always @(negedge clk) begin
        string name;
        if (rst_n) begin
            name = $sformatf("block %0d", blocks_done);
            if (sample_valid) begin
                strobe_count++;
                if (strobe_count % n_samples == 0) begin
                    strobe_cyc_q.push_back(cyc);
                end
            end
            if (beat_idx != 0 && !out_valid) begin
                $display("%s ended after %0d beats instead of %0d",
                         name, beat_idx, n_samples);
                block_err = 1'b1;
                repeat (n_samples - beat_idx) void'(mant_q.pop_front());
                close_block(name);
            end else if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("extra output beat at cycle %0d with no block pending", cyc);
                    stray_errors++;
                end else begin
                    record_beat(name);
                end
            end
        end
    end

    // Cycle counter and run limit.
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cycle_limit > 0 && cyc >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d blocks seen",
                     cyc, blocks_done, n_blocks);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int base;
        int gap;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_data  = '0;
        seed         = 32'hb505;
        cyc          = 0;
        strobe_count = 0;
        beat_idx     = 0;
        blocks_done  = 0;
        pass_count   = 0;
        fail_count   = 0;
        stray_errors = 0;
        block_err    = 1'b0;
        $readmemh("sim/bfp_testdata.txt", test_mem);
        n_blocks = 0;
        while (n_blocks < max_blocks && !$isunknown(test_mem[n_blocks*words_per_block])) begin
            n_blocks++;
        end
        if (n_blocks == 0) begin
            $display("no test blocks could be read from the data file");
        end
        cycle_limit = n_blocks * n_samples * 4 + 100;   // worst case gaps plus margin.
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int b = 0; b < n_blocks; b++) begin
            base = b * words_per_block;
            exp_q.push_back(bfp_pkg::bexp_t'(test_mem[base+5]));
            for (int i = 0; i < n_samples; i++) begin
                mant_q.push_back(bfp_pkg::mant_t'(test_mem[base+6+i]));
            end
            for (int i = 0; i < n_samples; i++) begin
                gap = (test_mem[base] != 0) ? ($unsigned($random(seed)) % 4) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    sample_valid <= 1'b0;
                end
                @(posedge clk);
                sample_valid <= 1'b1;
                sample_data  <= bfp_pkg::sample_t'(test_mem[base+1+i]);
            end
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        wait (blocks_done == n_blocks);
        repeat (8) @(posedge clk);          // room for any extra beats to show up.
        $display("blocks: %0d, passed: %0d, failed: %0d, extra beats: %0d, assert errors: %0d",
                 n_blocks, pass_count, fail_count, stray_errors, u_dut.u_sva.assert_errors);
        if (n_blocks > 0 && fail_count == 0 && stray_errors == 0 &&
            u_dut.u_sva.assert_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/bfp_testdata.txt */
// columns, all hex: gap mode (0 back to back, 1 random idle gaps), samples s0 s1 s2 s3,
// expected block exponent, expected mantissas m0 m1 m2 m3
//
// mixed magnitudes, back to back
0 0001 0010 0100 1000 c 01000 01000 01000 01000
0 0003 0005 0000 0007 2 00006 00005 00000 00007
0 0abc 0def 0123 0000 b 00abc 00def 00918 00000
0 1000 2000 0400 0800 d 02000 02000 02000 02000
//
// all zero block
0 0000 0000 0000 0000 0 00000 00000 00000 00000
//
// blocks that reach bit 15
0 8000 0001 00ff 1234 f 08000 08000 0ff00 091a0
0 ffff 7fff 0001 4000 f 0ffff 0fffe 08000 08000
//
// small and near full scale exponents
0 0002 0000 0000 0000 1 00002 00000 00000 00000
0 7fff 0000 0000 0001 e 07fff 00000 00000 04000
//
// random idle gaps between samples
1 0001 0001 0001 0001 0 00001 00001 00001 00001
1 00f0 0f00 000f f000 f 0f000 0f000 0f000 0f000
1 5555 00aa 0033 0004 e 05555 05500 06600 04000
1 0000 8000 0000 0000 f 00000 08000 00000 00000
1 0010 0020 0040 0080 7 00080 00080 00080 00080
1 0100 0000 00ff 0003 8 00100 00000 001fe 00180
1 0009 0006 0003 0001 3 00009 0000c 0000c 00008
//
// back to back again after the gapped blocks
0 0040 0000 0020 0001 6 00040 00000 00040 00040
0 c000 3000 0c00 0300 f 0c000 0c000 0c000 0c000

/* project.f */
common/bfp_pkg.sv
source/bfp_sample_buffer.sv
bfp_exponent/bfp_exponent_detect.sv
bfp_normalize/bfp_mantissa_shift.sv
source/bfp_block_encoder.sv
sim/bfp_sva.sv
sim/bfp_tb.sv

/* Bender.yml */
package:
  name: bfp_block_encoder

sources:
  - common/bfp_pkg.sv
  - source/bfp_sample_buffer.sv
  - bfp_exponent/bfp_exponent_detect.sv
  - bfp_normalize/bfp_mantissa_shift.sv
  - source/bfp_block_encoder.sv
  - target: simulation
    files:
      - sim/bfp_sva.sv
      - sim/bfp_tb.sv
